/* Bender.yml */
package:
  name: ooo_backend

sources:
  - include_dirs:
      - include
    files:
      - design/ooo_pkg.sv
      - design/dispatch_unit.sv
      - design/alu_station.sv
      - design/load_station.sv
      - design/reorder_buffer.sv
      - design/ooo_backend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/ooo_backend_assert.sv
      - dv/tb_ooo_backend.sv

/* design/alu_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module alu_station import ooo_pkg::*; (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  input  logic              predict_fail,

  input  logic              alu_push,
  input  uop_u              push_uop,
  input  logic [`TAG_W-1:0] push_tag,

  output logic              alu_full,

  // result towards the ROB rs port
  output logic              submit_valid,
  output logic [`TAG_W-1:0] submit_tag,
  output logic [`XLEN-1:0]  submit_val
);

  localparam int PTR_W = $clog2(`STATION_DEPTH);

  uop_u              fifo_uop [`STATION_DEPTH];
  logic [`TAG_W-1:0] fifo_tag [`STATION_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;

  logic              live;
  logic              do_push;
  logic              do_pop;

  uop_u              head_uop;
  logic [`XLEN-1:0]  op_a;
  logic [`XLEN-1:0]  op_b;
  logic [`XLEN-1:0]  alu_res;

  // execute stage
  logic              ex_valid;
  logic [`TAG_W-1:0] ex_tag;
  logic [`XLEN-1:0]  ex_val;

  assign live    = rdy_in && !predict_fail;
  assign do_push = live && alu_push;
  assign do_pop  = live && (count != '0);  // oldest entry leaves every cycle

  assign alu_full = (count == (PTR_W + 1)'(`STATION_DEPTH));

  assign head_uop = fifo_uop[rd_ptr];
  assign op_a     = `XLEN'(head_uop.alu.src_a);  // zero extended
  assign op_b     = `XLEN'(head_uop.alu.src_b);

  always_comb begin
    case (head_uop.alu.alu_op)
      ALU_ADD: alu_res = op_a + op_b;
      ALU_SUB: alu_res = op_a - op_b;  // wraps mod 2^32
      ALU_XOR: alu_res = op_a ^ op_b;
      default: alu_res = op_a & op_b;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      ex_valid <= 1'b0;
    end else if (rdy_in) begin
      if (predict_fail) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        ex_valid <= 1'b0;
      end else begin
        if (do_push) wr_ptr <= wr_ptr + 1'b1;
        if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        count    <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        ex_valid <= do_pop;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      fifo_uop[wr_ptr] <= push_uop;
      fifo_tag[wr_ptr] <= push_tag;
    end
    if (do_pop) begin
      ex_tag <= fifo_tag[rd_ptr];
      ex_val <= alu_res;
    end
  end

  assign submit_valid = ex_valid;
  assign submit_tag   = ex_tag;
  assign submit_val   = ex_val;

endmodule

`default_nettype wire

/* design/dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit import ooo_pkg::*; (
  input  logic clk_in,
  input  logic rst_in,
  input  logic rdy_in,
  input  logic predict_fail,

  // micro-op from the front end
  input  logic push_valid,
  input  uop_u push_uop,

  // occupancy levels
  input  logic rob_full,
  input  logic alu_full,
  input  logic load_full,

  output logic push_ready,
  output logic rob_push,
  output logic alu_push,
  output logic load_push
);

  logic armed;     // quiet through reset and the first live cycle after it
  logic is_mem;
  logic sel_full;
  logic take;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      armed <= 1'b0;
    end else if (rdy_in) begin
      armed <= 1'b1;
    end
  end

  // is_mem sits at the same position in both views
  assign is_mem = push_uop.mem.is_mem;

  // only the station this micro-op targets matters
  assign sel_full = is_mem ? load_full : alu_full;

  assign push_ready = armed && !rob_full && !sel_full;

  // no push while paused or while the ROB is being flushed
  assign take = push_valid && push_ready && rdy_in && !predict_fail;

  assign rob_push  = take;
  assign alu_push  = take && !is_mem;
  assign load_push = take && is_mem;  // exactly one station strobe per push

endmodule

`default_nettype wire

/* design/load_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module load_station import ooo_pkg::*; (
  input  logic                            clk_in,
  input  logic                            rst_in,
  input  logic                            rdy_in,
  input  logic                            predict_fail,

  input  logic                            load_push,
  input  uop_u                            push_uop,
  input  logic [`TAG_W-1:0]               push_tag,

  // external fill port of the data memory
  input  logic                            mem_wr_en,
  input  logic [$clog2(`LMEM_DEPTH)-1:0]  mem_wr_addr,
  input  logic [`XLEN-1:0]                mem_wr_data,

  output logic                            load_full,

  // result towards the ROB lsb port
  output logic                            submit_valid,
  output logic [`TAG_W-1:0]               submit_tag,
  output logic [`XLEN-1:0]                submit_val
);

  localparam int PTR_W = $clog2(`STATION_DEPTH);
  localparam int LA_W  = $clog2(`LMEM_DEPTH);

  logic [`XLEN-1:0]  lmem     [`LMEM_DEPTH];
  uop_u              fifo_uop [`STATION_DEPTH];
  logic [`TAG_W-1:0] fifo_tag [`STATION_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;

  logic              live;
  logic              do_push;
  logic              do_pop;

  uop_u              head_uop;
  logic [`XLEN-1:0]  addr_sum;
  logic [LA_W-1:0]   head_addr;

  logic              a1_valid;  // address stage
  logic [`TAG_W-1:0] a1_tag;
  logic [LA_W-1:0]   a1_addr;
  logic              r2_valid;  // read stage
  logic [`TAG_W-1:0] r2_tag;
  logic [`XLEN-1:0]  r2_val;

  assign live    = rdy_in && !predict_fail;
  assign do_push = live && load_push;
  assign do_pop  = live && (count != '0);

  assign load_full = (count == (PTR_W + 1)'(`STATION_DEPTH));

  assign head_uop  = fifo_uop[rd_ptr];
  assign addr_sum  = `XLEN'(head_uop.mem.base) + `XLEN'(head_uop.mem.offset);
  assign head_addr = LA_W'(addr_sum % `LMEM_DEPTH);  // word address wraps

  always_ff @(posedge clk_in) begin
    if (rdy_in && mem_wr_en) lmem[mem_wr_addr] <= mem_wr_data;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      a1_valid <= 1'b0;
      r2_valid <= 1'b0;
    end else if (rdy_in) begin
      if (predict_fail) begin  // memory contents survive a flush
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        a1_valid <= 1'b0;
        r2_valid <= 1'b0;
      end else begin
        if (do_push) wr_ptr <= wr_ptr + 1'b1;
        if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        count    <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        a1_valid <= do_pop;
        r2_valid <= a1_valid;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_push) begin
      fifo_uop[wr_ptr] <= push_uop;
      fifo_tag[wr_ptr] <= push_tag;
    end
    if (do_pop) begin
      a1_tag  <= fifo_tag[rd_ptr];
      a1_addr <= head_addr;
    end
    if (live && a1_valid) begin
      r2_tag <= a1_tag;
      r2_val <= lmem[a1_addr];
    end
  end

  assign submit_valid = r2_valid;
  assign submit_tag   = r2_tag;
  assign submit_val   = r2_val;

endmodule

`default_nettype wire

/* design/ooo_backend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module ooo_backend import ooo_pkg::*; (
  input  logic                            clk_in,
  input  logic                            rst_in,
  input  logic                            rdy_in,
  input  logic                            predict_fail,

  input  logic                            push_valid,
  input  uop_u                            push_uop,
  input  logic [`XLEN-1:0]                push_src_addr,
  input  logic [`RD_W-1:0]                push_rd_idx,
  output logic                            push_ready,

  input  logic                            mem_wr_en,
  input  logic [$clog2(`LMEM_DEPTH)-1:0]  mem_wr_addr,
  input  logic [`XLEN-1:0]                mem_wr_data,

  output logic                            commit_valid,
  output logic [`TAG_W-1:0]               commit_tag,
  output logic [`XLEN-1:0]                commit_val,
  output logic [`XLEN-1:0]                commit_addr,
  output logic [`RD_W-1:0]                commit_rd_idx
);

  logic              rob_push;
  logic              rob_full;
  logic [`TAG_W-1:0] push_rob_tag;

  logic              alu_push;
  logic              alu_full;
  logic              load_push;
  logic              load_full;

  // station results
  logic              alu_submit_valid;
  logic [`TAG_W-1:0] alu_submit_tag;
  logic [`XLEN-1:0]  alu_submit_val;
  logic              load_submit_valid;
  logic [`TAG_W-1:0] load_submit_tag;
  logic [`XLEN-1:0]  load_submit_val;

  dispatch_unit i_dispatch_unit (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .predict_fail (predict_fail),
    .push_valid   (push_valid),
    .push_uop     (push_uop),
    .rob_full     (rob_full),
    .alu_full     (alu_full),
    .load_full    (load_full),
    .push_ready   (push_ready),
    .rob_push     (rob_push),
    .alu_push     (alu_push),
    .load_push    (load_push)
  );

  alu_station i_alu_station (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .predict_fail (predict_fail),
    .alu_push     (alu_push),
    .push_uop     (push_uop),
    .push_tag     (push_rob_tag),
    .alu_full     (alu_full),
    .submit_valid (alu_submit_valid),
    .submit_tag   (alu_submit_tag),
    .submit_val   (alu_submit_val)
  );

  load_station i_load_station (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .predict_fail (predict_fail),
    .load_push    (load_push),
    .push_uop     (push_uop),
    .push_tag     (push_rob_tag),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_data  (mem_wr_data),
    .load_full    (load_full),
    .submit_valid (load_submit_valid),
    .submit_tag   (load_submit_tag),
    .submit_val   (load_submit_val)
  );

  // ALU results on the rs port, loads on the lsb port
  reorder_buffer i_reorder_buffer (
    .clk_in           (clk_in),
    .rst_in           (rst_in),
    .rdy_in           (rdy_in),
    .push_valid       (rob_push),
    .push_src_addr    (push_src_addr),
    .push_rd_idx      (push_rd_idx),
    .submit_tag_rs    (alu_submit_tag),
    .submit_val_rs    (alu_submit_val),
    .submit_valid_rs  (alu_submit_valid),
    .submit_tag_lsb   (load_submit_tag),
    .submit_val_lsb   (load_submit_val),
    .submit_valid_lsb (load_submit_valid),
    .predict_fail     (predict_fail),
    .push_rob_tag     (push_rob_tag),
    .rob_full         (rob_full),
    .cdb_tag          (commit_tag),
    .cdb_val          (commit_val),
    .cdb_addr         (commit_addr),
    .cdb_rd_idx       (commit_rd_idx),
    .cdb_active       (commit_valid)
  );

endmodule

`default_nettype wire

/* design/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

  // alu_op encodings
  localparam logic [1:0] ALU_ADD = 2'd0;
  localparam logic [1:0] ALU_SUB = 2'd1;
  localparam logic [1:0] ALU_XOR = 2'd2;
  localparam logic [1:0] ALU_AND = 2'd3;

  typedef struct packed {
    logic        is_mem;  // always 0 in this view
    logic [1:0]  alu_op;
    logic [4:0]  pad;
    logic [11:0] src_a;
    logic [11:0] src_b;
  } alu_uop_t;

  typedef struct packed {
    logic        is_mem;  // always 1 in this view
    logic [6:0]  pad;
    logic [11:0] base;
    logic [11:0] offset;
  } mem_uop_t;

  // one dispatched word, decoded by whichever station receives it
  typedef union packed {
    alu_uop_t alu;
    mem_uop_t mem;
  } uop_u;

endpackage

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module reorder_buffer (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,

  // allocation from dispatch
  input  logic              push_valid,
  input  logic [`XLEN-1:0]  push_src_addr,
  input  logic [`RD_W-1:0]  push_rd_idx,

  // results from the ALU station
  input  logic [`TAG_W-1:0] submit_tag_rs,
  input  logic [`XLEN-1:0]  submit_val_rs,
  input  logic              submit_valid_rs,

  // results from the load station
  input  logic [`TAG_W-1:0] submit_tag_lsb,
  input  logic [`XLEN-1:0]  submit_val_lsb,
  input  logic              submit_valid_lsb,

  input  logic              predict_fail,

  output logic [`TAG_W-1:0] push_rob_tag,
  output logic              rob_full,

  // in-order commit
  output logic [`TAG_W-1:0] cdb_tag,
  output logic [`XLEN-1:0]  cdb_val,
  output logic [`XLEN-1:0]  cdb_addr,
  output logic [`RD_W-1:0]  cdb_rd_idx,
  output logic              cdb_active
);

  // entry payload
  logic [`RD_W-1:0]       ent_rd   [`ROB_SIZE];
  logic [`TAG_W-1:0]      ent_tag  [`ROB_SIZE];
  logic [`XLEN-1:0]       ent_val  [`ROB_SIZE];
  logic [`XLEN-1:0]       ent_addr [`ROB_SIZE];

  logic [`ROB_SIZE-1:0]   ent_busy;
  logic [`ROB_SIZE-1:0]   ent_solved;

  logic [`ROB_SIZE_W-1:0] front;
  logic [`ROB_SIZE_W-1:0] rear;
  logic [`ROB_SIZE_W-1:0] front_nxt;
  logic [`ROB_SIZE_W-1:0] rear_nxt;

  logic [`ROB_SIZE-1:0]   hit_rs;
  logic [`ROB_SIZE-1:0]   hit_lsb;
  logic                   live;
  logic                   do_push;

  assign front_nxt = (front == `ROB_SIZE_W'(`ROB_SIZE - 1)) ? '0 : front + 1'b1;
  assign rear_nxt  = (rear == `ROB_SIZE_W'(`ROB_SIZE - 1)) ? '0 : rear + 1'b1;

  // one slot always stays empty so front == rear means empty
  assign rob_full = (rear_nxt == front);

  assign push_rob_tag = push_valid ? (`TAG_W'(rear) + `TAG_W'(1)) : '0;

  assign cdb_active = ent_solved[front];  // head solved -> commit now
  assign cdb_tag    = ent_tag[front];
  assign cdb_val    = ent_val[front];
  assign cdb_addr   = ent_addr[front];
  assign cdb_rd_idx = ent_rd[front];

  assign live    = rdy_in && !predict_fail;
  assign do_push = live && push_valid;

  // tag search over unsolved in-flight entries
  always_comb begin
    for (int i = 0; i < `ROB_SIZE; i++) begin
      hit_rs[i]  = submit_valid_rs && ent_busy[i] && !ent_solved[i] &&
                   (ent_tag[i] == submit_tag_rs);
      hit_lsb[i] = submit_valid_lsb && ent_busy[i] && !ent_solved[i] &&
                   (ent_tag[i] == submit_tag_lsb);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      front      <= '0;
      rear       <= '0;
      ent_busy   <= '0;
      ent_solved <= '0;
    end else if (rdy_in) begin
      if (predict_fail) begin  // drop everything in flight
        front      <= '0;
        rear       <= '0;
        ent_busy   <= '0;
        ent_solved <= '0;
      end else begin
        if (push_valid) rear <= rear_nxt;
        if (cdb_active) front <= front_nxt;
        for (int i = 0; i < `ROB_SIZE; i++) begin
          if (push_valid && rear == `ROB_SIZE_W'(i)) begin
            ent_busy[i]   <= 1'b1;
            ent_solved[i] <= 1'b0;
          end
          if (hit_rs[i] || hit_lsb[i]) ent_solved[i] <= 1'b1;
          if (cdb_active && front == `ROB_SIZE_W'(i)) begin  // pop head
            ent_busy[i]   <= 1'b0;
            ent_solved[i] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < `ROB_SIZE; i++) begin
      if (do_push && rear == `ROB_SIZE_W'(i)) begin
        ent_rd[i]   <= push_rd_idx;
        ent_tag[i]  <= push_rob_tag;
        ent_addr[i] <= push_src_addr;
      end
      // the two ports never hit the same slot
      if (live && hit_rs[i]) begin
        ent_val[i] <= submit_val_rs;
      end else if (live && hit_lsb[i]) begin
        ent_val[i] <= submit_val_lsb;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/ooo_backend_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module ooo_backend_assert (
  input logic              clk_in,
  input logic              rst_in,
  input logic              rdy_in,
  input logic              predict_fail,
  input logic              push_ready,
  input logic              rob_full,
  input logic              commit_valid,
  input logic [`TAG_W-1:0] commit_tag
);

  int                failures = 0;
  logic              commit_fire;
  logic              flush;
  logic              seen_commit;  // a commit since reset or the last flush
  logic [`TAG_W-1:0] last_tag;
  logic [`TAG_W-1:0] next_tag;

  assign commit_fire = commit_valid && rdy_in && !predict_fail;
  assign flush       = rdy_in && predict_fail;  // ignored while paused
  assign next_tag    = (last_tag == `TAG_W'(`ROB_SIZE)) ? `TAG_W'(1) : last_tag + 1'b1;

  always_ff @(posedge clk_in) begin
    if (rst_in || flush) begin
      seen_commit <= 1'b0;
    end else if (commit_fire) begin
      seen_commit <= 1'b1;
      last_tag    <= commit_tag;
    end
  end

  commit_quiet_in_reset: assert property (@(posedge clk_in) rst_in |=> !commit_valid)
    else begin
      $error("commit_valid high after a reset edge");
      failures++;
    end

  ready_low_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
    rob_full |-> !push_ready)
    else begin
      $error("push_ready high while the ROB is full");
      failures++;
    end

  tags_in_sequence: assert property (@(posedge clk_in) disable iff (rst_in)
    (commit_fire && seen_commit) |-> commit_tag == next_tag)
    else begin
      $error("commit tag %0d does not follow %0d", commit_tag, last_tag);
      failures++;
    end

endmodule

`default_nettype wire

/* dv/tb_ooo_backend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_params.svh"

module tb_ooo_backend import ooo_pkg::*; ();

  localparam int HALF_PERIOD   = 20;  // 40 ns clock
  localparam int PUSH_TIMEOUT  = 50;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int READY_TIMEOUT = 20;

  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  val;
    logic [`XLEN-1:0]  addr;
    logic [`RD_W-1:0]  rd;
  } exp_t;

  logic                           clk_in;
  logic                           rst_in;
  logic                           rdy_in;
  logic                           predict_fail;
  logic                           push_valid;
  uop_u                           push_uop;
  logic [`XLEN-1:0]               push_src_addr;
  logic [`RD_W-1:0]               push_rd_idx;
  logic                           push_ready;
  logic                           mem_wr_en;
  logic [$clog2(`LMEM_DEPTH)-1:0] mem_wr_addr;
  logic [`XLEN-1:0]               mem_wr_data;
  logic                           commit_valid;
  logic [`TAG_W-1:0]              commit_tag;
  logic [`XLEN-1:0]               commit_val;
  logic [`XLEN-1:0]               commit_addr;
  logic [`RD_W-1:0]               commit_rd_idx;

  logic [`XLEN-1:0]  tb_mem [`LMEM_DEPTH];  // copy of the load memory
  exp_t              exp_q [$];             // accepted pushes in order
  logic [`TAG_W-1:0] next_tag;
  logic              after_flush;
  int                errors = 0;
  int                checks = 0;
  event              run_done;              // stimulus finished or gave up

  ooo_backend i_ooo_backend (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rdy_in        (rdy_in),
    .predict_fail  (predict_fail),
    .push_valid    (push_valid),
    .push_uop      (push_uop),
    .push_src_addr (push_src_addr),
    .push_rd_idx   (push_rd_idx),
    .push_ready    (push_ready),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .commit_valid  (commit_valid),
    .commit_tag    (commit_tag),
    .commit_val    (commit_val),
    .commit_addr   (commit_addr),
    .commit_rd_idx (commit_rd_idx)
  );

  bind ooo_backend ooo_backend_assert i_ooo_backend_assert (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .predict_fail (predict_fail),
    .push_ready   (push_ready),
    .rob_full     (rob_full),
    .commit_valid (commit_valid),
    .commit_tag   (commit_tag)
  );

  initial begin
    clk_in = 1'b0;
    forever #HALF_PERIOD clk_in = ~clk_in;
  end

  // expected result straight from the micro-op encoding
  function automatic logic [`XLEN-1:0] ref_value(input uop_u u);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    int unsigned      word;
    a = `XLEN'(u.alu.src_a);
    b = `XLEN'(u.alu.src_b);
    if (u.mem.is_mem) begin
      word = (`XLEN'(u.mem.base) + `XLEN'(u.mem.offset)) % `LMEM_DEPTH;
      return tb_mem[word];
    end
    case (u.alu.alu_op)
      2'd0:    return a + b;
      2'd1:    return a - b;  // wraps mod 2^32
      2'd2:    return a ^ b;
      default: return a & b;
    endcase
  endfunction

  function automatic uop_u rand_uop(input logic want_load);
    uop_u u;
    u = '0;  // pads stay zero
    if (want_load) begin
      u.mem.is_mem = 1'b1;
      u.mem.base   = 12'($urandom);
      u.mem.offset = 12'($urandom);
    end else begin
      u.alu.alu_op = 2'($urandom);
      u.alu.src_a  = 12'($urandom);
      u.alu.src_b  = 12'($urandom);
    end
    return u;
  endfunction

  task automatic end_run();
    int total;
    total = errors + i_ooo_backend.i_ooo_backend_assert.failures;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             checks, errors, i_ooo_backend.i_ooo_backend_assert.failures);
    if (total == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  endtask

  task automatic give_up(input string what);
    errors++;
    $display("timeout: %s", what);
    -> run_done;
  endtask

  task automatic flag_mismatch(input string field, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] want);
    errors++;
    $display("ERROR @%0t: commit %s is %0h, expected %0h", $time, field, got, want);
  endtask

  task automatic wait_push_ready();
    int waited;
    waited = 0;
    while (!push_ready && waited < READY_TIMEOUT) begin
      @(negedge clk_in);
      waited++;
    end
    if (!push_ready) give_up("push_ready never rose after reset");
  endtask

  task automatic preload_memory();
    logic [`XLEN-1:0] word;
    for (int i = 0; i < `LMEM_DEPTH; i++) begin
      @(negedge clk_in);
      word        = $urandom;
      mem_wr_en   = 1'b1;
      mem_wr_addr = i[$clog2(`LMEM_DEPTH)-1:0];
      mem_wr_data = word;
      tb_mem[i]   = word;
    end
    @(negedge clk_in);
    mem_wr_en = 1'b0;
  endtask

  // offer one micro-op and hold it until the back end takes it
  task automatic push_op(input uop_u u, input logic [`XLEN-1:0] addr,
                         input logic [`RD_W-1:0] rd);
    exp_t e;
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    @(negedge clk_in);
    push_valid    = 1'b1;
    push_uop      = u;
    push_src_addr = addr;
    push_rd_idx   = rd;
    while (!taken && waited < PUSH_TIMEOUT) begin
      @(posedge clk_in);
      taken = push_valid && push_ready && rdy_in && !predict_fail;
      waited++;
    end
    if (taken) begin
      e.tag  = next_tag;
      e.val  = ref_value(u);
      e.addr = addr;
      e.rd   = rd;
      exp_q.push_back(e);
      next_tag = (next_tag == `TAG_W'(`ROB_SIZE)) ? `TAG_W'(1) : next_tag + 1'b1;
    end else begin
      give_up("push was never accepted");
    end
  endtask

  task automatic push_random(input int count, input int load_pct);
    uop_u u;
    for (int i = 0; i < count; i++) begin
      u = rand_uop(($urandom % 100) < load_pct);
      push_op(u, $urandom, `RD_W'($urandom));
    end
  endtask

  task automatic drain(input string what);
    int waited;
    waited = 0;
    @(negedge clk_in);
    push_valid = 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk_in);
      waited++;
    end
    if (exp_q.size() != 0) give_up({"outstanding micro-ops never committed in ", what});
  endtask

  task automatic flush_pipeline();
    @(negedge clk_in);
    push_valid   = 1'b0;  // a push next to the strobe would be dropped anyway
    predict_fail = 1'b1;
    @(posedge clk_in);
    exp_q.delete();
    next_tag    = `TAG_W'(1);
    after_flush = 1'b1;
    @(negedge clk_in);
    predict_fail = 1'b0;
  endtask

  // commit outputs hold still through a stall with a push on offer
  task automatic pause_cycles(input int cycles);
    logic              held_valid;
    logic [`TAG_W-1:0] held_tag;
    @(negedge clk_in);
    rdy_in     = 1'b0;
    push_valid = 1'b1;
    held_valid = commit_valid;
    held_tag   = commit_tag;
    repeat (cycles) begin
      @(negedge clk_in);
      checks++;
      if (commit_valid !== held_valid || (held_valid && commit_tag !== held_tag)) begin
        errors++;
        $display("ERROR @%0t: commit state moved while rdy_in was low", $time);
      end
    end
    push_valid = 1'b0;
    rdy_in     = 1'b1;
  endtask

  // commit checker
  always @(posedge clk_in) begin
    exp_t e;
    if (!rst_in && rdy_in && !predict_fail && commit_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR @%0t: commit of tag %0d with nothing outstanding", $time, commit_tag);
      end else begin
        e = exp_q.pop_front();
        checks++;
        if (commit_tag !== e.tag) flag_mismatch("tag", `XLEN'(commit_tag), `XLEN'(e.tag));
        if (commit_val !== e.val) flag_mismatch("value", commit_val, e.val);
        if (commit_addr !== e.addr) flag_mismatch("address", commit_addr, e.addr);
        if (commit_rd_idx !== e.rd) flag_mismatch("rd index", `XLEN'(commit_rd_idx), `XLEN'(e.rd));
      end
      if (after_flush) begin
        if (commit_tag !== `TAG_W'(1)) begin
          errors++;
          $display("ERROR @%0t: first commit after flush has tag %0d", $time, commit_tag);
        end
        after_flush = 1'b0;
      end
    end
  end

  // seven in flight means the ROB must refuse
  always @(negedge clk_in) begin
    if (!rst_in && push_ready && exp_q.size() >= `ROB_SIZE - 1) begin
      errors++;
      $display("ERROR @%0t: push_ready high with %0d micro-ops outstanding",
               $time, exp_q.size());
    end
  end

  initial begin
    @(run_done);
    end_run();
  end

  initial begin
    rst_in        = 1'b1;
    rdy_in        = 1'b1;
    predict_fail  = 1'b0;
    push_valid    = 1'b0;
    push_uop      = '0;
    push_src_addr = '0;
    push_rd_idx   = '0;
    mem_wr_en     = 1'b0;
    mem_wr_addr   = '0;
    mem_wr_data   = '0;
    next_tag      = `TAG_W'(1);
    after_flush   = 1'b0;
    void'($urandom(32'h204817ef));

    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst_in = 1'b0;
    wait_push_ready();
    preload_memory();

    push_random(20, 0);  // ALU only so tags wrap twice
    drain("the ALU-only stream");

    push_op(rand_uop(1'b1), $urandom, `RD_W'($urandom));  // load ahead of younger ALU ops
    push_op(rand_uop(1'b0), $urandom, `RD_W'($urandom));
    push_op(rand_uop(1'b0), $urandom, `RD_W'($urandom));
    push_random(40, 50);
    drain("the mixed stream");

    push_random(5, 60);
    flush_pipeline();
    repeat (6) @(negedge clk_in);  // nothing from before the flush may show up
    push_random(10, 50);
    drain("the stream after the flush");

    push_random(4, 50);
    pause_cycles(6);
    push_random(8, 50);
    drain("the stream after the pause");

    -> run_done;
  end

endmodule

`default_nettype wire

/* include/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// reorder buffer geometry
`define ROB_SIZE      8
`define ROB_SIZE_W    3

// tag = slot index + 1, tag 0 is reserved for "no tag"
`define TAG_W         4

`define XLEN          32  // data and address words
`define RD_W          5   // destination register index

// per-station FIFO depth, keep it a power of two
`define STATION_DEPTH 4

// load data memory, power of two as well
`define LMEM_DEPTH    16

`endif

/* verilog.f */
+incdir+include
design/ooo_pkg.sv
design/dispatch_unit.sv
design/alu_station.sv
design/load_station.sv
design/reorder_buffer.sv
design/ooo_backend.sv
dv/ooo_backend_assert.sv
dv/tb_ooo_backend.sv
